/* hdl/div_ctrl.sv */
//--------------------------------------------------------------------------
// divider control
// three-state FSM with step counter, drives val/rdy and datapath strobes
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "imuldiv_macros.svh"

module div_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         req_val,
  input  logic                         resp_rdy,
  output logic                         req_rdy,
  output logic                         resp_val,
  output imuldiv_dpath_pkg::div_ctrl_t ctrl
);

  imuldiv_dpath_pkg::div_state_e state;
  imuldiv_dpath_pkg::div_state_e state_next;
  logic [`IMULDIV_CNT_W-1:0]     count;
  logic                          req_go;
  logic                          resp_go;
  logic                          last_step;

  // handshake fires
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // final iteration of CALC
  assign last_step = (count == `IMULDIV_CNT_W'(`IMULDIV_STEPS - 1));

  //------------------------------------------------------------------------
  // next state
  //------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      imuldiv_dpath_pkg::IDLE: begin
        if (req_go) state_next = imuldiv_dpath_pkg::CALC;
      end
      imuldiv_dpath_pkg::CALC: begin
        if (last_step) state_next = imuldiv_dpath_pkg::DONE;
      end
      imuldiv_dpath_pkg::DONE: begin
        // hold here under back-pressure
        if (resp_go) state_next = imuldiv_dpath_pkg::IDLE;
      end
      default: state_next = imuldiv_dpath_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_dpath_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // step counter, restarts with each new request
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ctrl.load) begin
      count <= '0;
    end else if (ctrl.step) begin
      count <= count + 1'b1;
    end
  end

  //------------------------------------------------------------------------
  // outputs, all decoded from state
  //------------------------------------------------------------------------
  always_comb begin
    req_rdy   = (state == imuldiv_dpath_pkg::IDLE);
    resp_val  = (state == imuldiv_dpath_pkg::DONE);
    // load only on the accept cycle
    ctrl.load = req_go;
    // 32 CALC cycles give 32 steps
    ctrl.step = (state == imuldiv_dpath_pkg::CALC);
  end

  // request and response sides never open together
  rdy_val_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(req_rdy && resp_val));

  // datapath never loads mid-iteration
  load_step_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(ctrl.load && ctrl.step));

endmodule

/* hdl/div_operand_unsign.sv */
//--------------------------------------------------------------------------
// divider operand capture
// registers operand magnitudes and the sign/zero flags for the result fix-up
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "imuldiv_macros.svh"

module div_operand_unsign (
  input  logic                            clk,
  input  logic                            reset,
  input  imuldiv_dpath_pkg::div_ctrl_t    ctrl,
  input  imuldiv_msg_pkg::div_req_msg_t   req_msg,
  output imuldiv_msg_pkg::word_t          a_mag,
  output imuldiv_msg_pkg::word_t          b_mag,
  output imuldiv_dpath_pkg::div_sign_t    sign
);

  logic                   is_signed;
  logic                   a_neg;
  logic                   b_neg;
  imuldiv_msg_pkg::word_t a_abs;
  imuldiv_msg_pkg::word_t b_abs;

  // sign bits only count for div/rem
  assign is_signed = (req_msg.fn == imuldiv_msg_pkg::DIV_FN_SIGNED);
  assign a_neg     = is_signed && req_msg.a[`IMULDIV_XLEN-1];
  assign b_neg     = is_signed && req_msg.b[`IMULDIV_XLEN-1];

  // two's complement magnitude, most negative value maps to itself
  assign a_abs = a_neg ? (~req_msg.a + 1'b1) : req_msg.a;
  assign b_abs = b_neg ? (~req_msg.b + 1'b1) : req_msg.b;

  // magnitudes, held stable for the whole CALC phase
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      a_mag <= a_abs;
      b_mag <= b_abs;
    end
  end

  // sign record
  always_ff @(posedge clk) begin
    if (reset) begin
      sign <= '0;
    end else if (ctrl.load) begin
      sign.neg_quot <= a_neg ^ b_neg;
      // remainder follows the dividend
      sign.neg_rem  <= a_neg;
      sign.b_zero   <= (req_msg.b == '0);
    end
  end

endmodule

/* hdl/div_result_sign.sv */
//--------------------------------------------------------------------------
// divider result sign fix-up
// restores quotient and remainder signs and packs the response message
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module div_result_sign (
  input  imuldiv_dpath_pkg::div_sign_t   sign,
  input  imuldiv_msg_pkg::word_t         rem,
  input  imuldiv_msg_pkg::word_t         quot,
  output imuldiv_msg_pkg::div_resp_msg_t resp_msg
);

  logic                   neg_quot_eff;
  imuldiv_msg_pkg::word_t quot_out;
  imuldiv_msg_pkg::word_t rem_out;

  // divide by zero leaves the all-ones quotient untouched
  // in both modes, only the dividend sign could flip it
  assign neg_quot_eff = sign.neg_quot && !sign.b_zero;

  //------------------------------------------------------------------------
  // negation
  //------------------------------------------------------------------------

  // most negative / -1 gives 0x80000000 magnitude with both signs set,
  // so no negation and the dividend comes back as quotient
  assign quot_out = neg_quot_eff ? (~quot + 1'b1) : quot;

  // remainder takes the dividend sign, covers divide by zero too
  assign rem_out = sign.neg_rem ? (~rem + 1'b1) : rem;

  // response word, remainder high and quotient low
  always_comb begin
    resp_msg.rem  = rem_out;
    resp_msg.quot = quot_out;
  end

endmodule

/* hdl/div_shift_sub.sv */
//--------------------------------------------------------------------------
// restoring shift-subtract divider core
// one quotient bit per step on unsigned magnitudes
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "imuldiv_macros.svh"

module div_shift_sub (
  input  logic                         clk,
  input  logic                         reset,
  input  imuldiv_dpath_pkg::div_ctrl_t ctrl,
  input  imuldiv_msg_pkg::word_t       a_mag,
  input  imuldiv_msg_pkg::word_t       b_mag,
  output imuldiv_msg_pkg::word_t       rem,
  output imuldiv_msg_pkg::word_t       quot
);

  imuldiv_dpath_pkg::dword_t work;
  imuldiv_dpath_pkg::dword_t base;
  imuldiv_dpath_pkg::dword_t shifted;
  imuldiv_dpath_pkg::dword_t diff;
  logic                      fresh;

  //------------------------------------------------------------------------
  // iteration datapath
  //------------------------------------------------------------------------

  // magnitudes land on the same edge as load, so the zero-extended
  // dividend is muxed in as the starting value of the first step
  assign base = fresh ? {{(`IMULDIV_XLEN + 1){1'b0}}, a_mag} : work;

  // next dividend bit moves into the remainder half
  assign shifted = base << 1;

  // trial subtract with divisor aligned to the remainder half
  assign diff = shifted - {1'b0, b_mag, {`IMULDIV_XLEN{1'b0}}};

  // marks the first step after a load
  always_ff @(posedge clk) begin
    if (reset) begin
      fresh <= 1'b0;
    end else if (ctrl.load) begin
      fresh <= 1'b1;
    end else if (ctrl.step) begin
      fresh <= 1'b0;
    end
  end

  // working register, holds once the steps stop
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      // remainder half starts empty
      work <= '0;
    end else if (ctrl.step) begin
      if (diff[2*`IMULDIV_XLEN]) begin
        // negative trial, restore the shifted value
        work <= shifted;
      end else begin
        // subtract fits, quotient bit one
        work <= {diff[2*`IMULDIV_XLEN:1], 1'b1};
      end
    end
  end

  // remainder in bits 63:32, quotient in 31:0
  assign rem  = work[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];
  assign quot = work[`IMULDIV_XLEN-1:0];

  // when stepping stops the remainder is reduced below the divisor
  rem_below_divisor: assert property (@(posedge clk) disable iff (reset)
    ($fell(ctrl.step) && (b_mag != '0)) |-> (rem < b_mag));

endmodule

/* hdl/imuldiv_dpath_pkg.sv */
//--------------------------------------------------------------------------
// divider internal types
// FSM states, control strobes and operand sign record
//--------------------------------------------------------------------------

`include "imuldiv_macros.svh"

package imuldiv_dpath_pkg;

  // control FSM states
  typedef enum logic [1:0] {IDLE, CALC, DONE} div_state_e;

  // per-cycle strobes from control to datapath
  typedef struct packed {
    logic load;   // capture request, start working register
    logic step;   // one shift-subtract iteration
  } div_ctrl_t;

  // sign fix-up info recorded at load time
  typedef struct packed {
    logic neg_quot;
    logic neg_rem;
    logic b_zero;
  } div_sign_t;

  // working register: guard bit, remainder, quotient
  typedef logic [2*`IMULDIV_XLEN:0] dword_t;

endpackage

/* hdl/imuldiv_macros.svh */
//--------------------------------------------------------------------------
// divider unit constants
// operand width, iteration count and step counter width
//--------------------------------------------------------------------------

`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

//--------------------------------------------------------------------------
// datapath widths
//--------------------------------------------------------------------------

// operand and result word width
`define IMULDIV_XLEN 32

//--------------------------------------------------------------------------
// iteration control
//--------------------------------------------------------------------------

// one restoring step per quotient bit
`define IMULDIV_STEPS 32

// counter must reach IMULDIV_STEPS-1
`define IMULDIV_CNT_W 5

`endif

/* hdl/imuldiv_msg_pkg.sv */
//--------------------------------------------------------------------------
// divider message types
// request and response layouts seen on the val/rdy ports
//--------------------------------------------------------------------------

`include "imuldiv_macros.svh"

package imuldiv_msg_pkg;

  // one operand or result word
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // function code, signed div/rem or unsigned divu/remu
  typedef enum logic {DIV_FN_SIGNED = 1'b0, DIV_FN_UNSIGNED = 1'b1} div_fn_e;

  //------------------------------------------------------------------------
  // request, fn in the top bit, then dividend and divisor
  //------------------------------------------------------------------------
  typedef struct packed {
    div_fn_e fn;
    word_t   a;
    word_t   b;
  } div_req_msg_t;

  //------------------------------------------------------------------------
  // response, remainder in the upper word, quotient in the lower word
  //------------------------------------------------------------------------
  typedef struct packed {
    word_t rem;
    word_t quot;
  } div_resp_msg_t;

endpackage

/* hdl/int_div_iterative.sv */
//--------------------------------------------------------------------------
// iterative 32-bit integer divider
// control FSM plus operand, shift-subtract and sign fix-up datapath
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module int_div_iterative (
  input  logic                           clk,
  input  logic                           reset,
  input  imuldiv_msg_pkg::div_req_msg_t  req_msg,
  input  logic                           req_val,
  output logic                           req_rdy,
  output imuldiv_msg_pkg::div_resp_msg_t resp_msg,
  output logic                           resp_val,
  input  logic                           resp_rdy
);

  // control strobes to datapath
  imuldiv_dpath_pkg::div_ctrl_t ctrl;

  // datapath internals
  imuldiv_msg_pkg::word_t       a_mag;
  imuldiv_msg_pkg::word_t       b_mag;
  imuldiv_dpath_pkg::div_sign_t sign;
  imuldiv_msg_pkg::word_t       rem;
  imuldiv_msg_pkg::word_t       quot;

  div_ctrl ctrl0 (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .ctrl     (ctrl)
  );

  div_operand_unsign unsign0 (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .req_msg (req_msg),
    .a_mag   (a_mag),
    .b_mag   (b_mag),
    .sign    (sign)
  );

  div_shift_sub shift_sub0 (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .a_mag (a_mag),
    .b_mag (b_mag),
    .rem   (rem),
    .quot  (quot)
  );

  // combinational, response stable while the core holds in DONE
  div_result_sign result_sign0 (
    .sign     (sign),
    .rem      (rem),
    .quot     (quot),
    .resp_msg (resp_msg)
  );

endmodule

/* src.f */
+incdir+hdl
hdl/imuldiv_msg_pkg.sv
hdl/imuldiv_dpath_pkg.sv
hdl/div_ctrl.sv
hdl/div_operand_unsign.sv
hdl/div_shift_sub.sv
hdl/div_result_sign.sv
hdl/int_div_iterative.sv
verif/tb_clk_gen.sv
verif/tb_int_div.sv

/* verif/tb_clk_gen.sv */
//--------------------------------------------------------------------------
// testbench clock and reset source
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic reset
);

  // free running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset covers the first RESET_CYCLES rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    reset <= 1'b0;
  end

endmodule

/* verif/tb_int_div.sv */
//--------------------------------------------------------------------------
// iterative divider testbench
// directed and random division requests checked against a reference model
//--------------------------------------------------------------------------

`timescale 1ns/1ps

`include "imuldiv_macros.svh"

module tb_int_div;

  // 6 + 20 unsigned, 6 signed, 5 special, 3 back-pressure
  localparam int NUM_OPS       = 40;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 200;
  localparam int WAIT_LIMIT    = `IMULDIV_STEPS + 8;

  logic                           clk;
  logic                           reset;
  imuldiv_msg_pkg::div_req_msg_t  req_msg;
  logic                           req_val;
  logic                           req_rdy;
  imuldiv_msg_pkg::div_resp_msg_t resp_msg;
  logic                           resp_val;
  logic                           resp_rdy;

  int     errors      = 0;
  int     checks      = 0;
  int     cycle_count = 0;
  integer seed;

  tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(2)) clk_gen0 (.clk(clk), .reset(reset));

  int_div_iterative dut0 (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  //--------------------------------------------------------------------------
  // reference model and compare helpers
  //--------------------------------------------------------------------------

  // divide by zero and most negative / -1 follow fixed rules
  function automatic imuldiv_msg_pkg::div_resp_msg_t expected_result(
    input imuldiv_msg_pkg::div_fn_e fn, input imuldiv_msg_pkg::word_t a,
    input imuldiv_msg_pkg::word_t b);
    imuldiv_msg_pkg::div_resp_msg_t r;
    int                             sa;
    int                             sb;
    sa = a;
    sb = b;
    if (b == '0) begin
      r.quot = '1;
      r.rem  = a;
    end else if (fn == imuldiv_msg_pkg::DIV_FN_UNSIGNED) begin
      r.quot = a / b;
      r.rem  = a % b;
    end else if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      r.quot = a;
      r.rem  = '0;
    end else begin
      // int division truncates toward zero, remainder keeps the dividend sign
      r.quot = sa / sb;
      r.rem  = sa % sb;
    end
    return r;
  endfunction

  task automatic compare_word(input string name, input string field,
                              input imuldiv_msg_pkg::word_t exp,
                              input imuldiv_msg_pkg::word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s %s: expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic compare_int(input string name, input string field, input int exp,
                             input int act);
    checks++;
    assert (act == exp) else begin
      errors++;
      $display("Mismatch %s %s: expected %0d actual %0d", name, field, exp, act);
    end
  endtask

  //--------------------------------------------------------------------------
  // one request/response transaction, starts and ends just after a falling edge
  //--------------------------------------------------------------------------
  task automatic send_and_check(input string name, input imuldiv_msg_pkg::div_fn_e fn,
                                input imuldiv_msg_pkg::word_t a,
                                input imuldiv_msg_pkg::word_t b, input int stall);
    imuldiv_msg_pkg::div_resp_msg_t exp;
    int                             lat;
    exp = expected_result(fn, a, b);
    compare_int(name, "req_rdy before request", 1, req_rdy);
    req_msg.fn = fn;
    req_msg.a  = a;
    req_msg.b  = b;
    req_val    = 1'b1;
    resp_rdy   = (stall == 0);
    @(negedge clk);
    req_val = 1'b0;
    // count falling edges that still see resp_val low
    lat = 0;
    while (!resp_val && lat < WAIT_LIMIT) begin
      compare_int(name, "req_rdy while busy", 0, req_rdy);
      lat++;
      @(negedge clk);
    end
    checks++;
    assert (resp_val) else begin
      errors++;
      $display("%s: no response within %0d cycles of the request", name, WAIT_LIMIT);
    end
    compare_int(name, "latency", `IMULDIV_STEPS, lat);
    compare_word(name, "quot", exp.quot, resp_msg.quot);
    compare_word(name, "rem", exp.rem, resp_msg.rem);
    // stall the response with a decoy request pending on the input side
    if (stall > 0) begin
      req_msg.a = ~a;
      req_msg.b = ~b;
      req_val   = 1'b1;
      repeat (stall) begin
        @(negedge clk);
        compare_int(name, "resp_val held", 1, resp_val);
        compare_int(name, "req_rdy held", 0, req_rdy);
        compare_word(name, "quot held", exp.quot, resp_msg.quot);
        compare_word(name, "rem held", exp.rem, resp_msg.rem);
      end
      req_val  = 1'b0;
      resp_rdy = 1'b1;
    end
    @(negedge clk);
    compare_int(name, "resp_val after consume", 0, resp_val);
    compare_int(name, "req_rdy after consume", 1, req_rdy);
  endtask

  //--------------------------------------------------------------------------
  // directed tests
  //--------------------------------------------------------------------------
  task automatic reset_state_checks;
    compare_int("after_reset", "req_rdy", 1, req_rdy);
    compare_int("after_reset", "resp_val", 0, resp_val);
  endtask

  task automatic unsigned_division;
    imuldiv_msg_pkg::word_t a;
    imuldiv_msg_pkg::word_t b;
    send_and_check("divu_100_7", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 100, 7, 0);
    send_and_check("divu_7_100", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 7, 100, 0);
    send_and_check("divu_max_1", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 32'hffff_ffff, 1, 0);
    send_and_check("divu_max_max", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 32'hffff_ffff,
                   32'hffff_ffff, 0);
    send_and_check("divu_msb_3", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 32'h8000_0000, 3, 0);
    send_and_check("divu_mid", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 32'h1234_5678, 1000, 0);
    for (int i = 0; i < 20; i++) begin
      a = $random(seed);
      b = $random(seed);
      // shrink the divisor so quotients spread over all widths
      b = b >> ($unsigned($random(seed)) % 32);
      send_and_check($sformatf("divu_rand_%0d", i), imuldiv_msg_pkg::DIV_FN_UNSIGNED,
                     a, b, 0);
    end
  endtask

  task automatic signed_division;
    send_and_check("div_pos_pos", imuldiv_msg_pkg::DIV_FN_SIGNED, 100, 7, 0);
    send_and_check("div_neg_pos", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd100, 7, 0);
    send_and_check("div_pos_neg", imuldiv_msg_pkg::DIV_FN_SIGNED, 100, -32'sd7, 0);
    send_and_check("div_neg_neg", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd100, -32'sd7, 0);
    // remainder takes the dividend sign
    send_and_check("div_neg_rem", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd7, 2, 0);
    send_and_check("div_small_big", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd1,
                   32'h7fff_ffff, 0);
  endtask

  task automatic zero_and_overflow;
    send_and_check("divu_by_zero", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 12345, 0, 0);
    send_and_check("divu_max_by_zero", imuldiv_msg_pkg::DIV_FN_UNSIGNED, 32'hffff_ffff,
                   0, 0);
    send_and_check("div_by_zero", imuldiv_msg_pkg::DIV_FN_SIGNED, 1234, 0, 0);
    send_and_check("div_neg_by_zero", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd1234, 0, 0);
    send_and_check("div_overflow", imuldiv_msg_pkg::DIV_FN_SIGNED, 32'h8000_0000,
                   32'hffff_ffff, 0);
  endtask

  task automatic response_backpressure;
    send_and_check("stall_divu", imuldiv_msg_pkg::DIV_FN_UNSIGNED, $random(seed), 977,
                   1 + ($unsigned($random(seed)) % 6));
    send_and_check("stall_div", imuldiv_msg_pkg::DIV_FN_SIGNED, -32'sd98765, 321,
                   1 + ($unsigned($random(seed)) % 6));
    send_and_check("stall_div_neg", imuldiv_msg_pkg::DIV_FN_SIGNED, $random(seed),
                   -32'sd13, 1 + ($unsigned($random(seed)) % 6));
  endtask

  //--------------------------------------------------------------------------
  // run control
  //--------------------------------------------------------------------------
  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("timeout after %0d cycles, checks: %0d errors: %0d", cycle_count, checks,
             errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    seed     = 32'h7a9ee333;
    req_msg  = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    @(negedge clk);
    while (reset) @(negedge clk);
    reset_state_checks();
    unsigned_division();
    signed_division();
    zero_and_overflow();
    response_backpressure();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
